// ==== Makefile ====
# Verilator build and run for the sequential divider testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_seq_divider
FILELIST  := vlog.f
BUILD_DIR := obj_dir

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== div_controller.sv ====
`timescale 1ns/1ps

module div_controller
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      src_valid,   // Operands offered by the source
    input  logic      dest_ready,  // Sink can take a result
    input  logic      count_done,  // Current step is the last one
    input  logic      sub_msb,     // Sign of the partial remainder
    output logic      src_ready,
    output logic      dest_valid,
    output logic      count_load,  // Preset the step counter
    output logic      clear,       // Zero the step counter
    output div_ctrl_t ctrl
);

    div_state_t state, next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Mealy outputs and next state
    always_comb begin
        next_state  = state;
        src_ready   = 1'b0;
        dest_valid  = 1'b0;
        count_load  = 1'b0;
        clear       = 1'b0;
        ctrl        = '0;
        ctrl.alu_op = ALU_SUB;

        case (state)
            IDLE: begin
                src_ready = 1'b1;
                if (src_valid) begin
                    ctrl.load  = 1'b1;   // Operands transfer on this edge
                    count_load = 1'b1;
                    next_state = RUN;
                end
            end

            RUN: begin
                ctrl.step = 1'b1;
                // Negative remainder adds the divisor back in this step
                ctrl.alu_op = sub_msb ? ALU_ADD : ALU_SUB;

                if (count_done) begin
                    ctrl.hold  = 1'b1;   // Datapath bypasses the fresh result
                    dest_valid = 1'b1;
                    clear      = 1'b1;
                    if (dest_ready) begin
                        src_ready  = 1'b1;
                        next_state = IDLE;
                    end else begin
                        next_state = WAIT;
                    end
                end
            end

            WAIT: begin
                dest_valid = 1'b1;       // Held result stays on the port
                if (dest_ready) begin
                    src_ready  = 1'b1;
                    next_state = IDLE;
                end
            end

            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // State register only ever holds a legal encoding
    a_state_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        state inside {IDLE, RUN, WAIT}
    ) else $error("Controller left the legal state set");

    // Offered result is not withdrawn before the sink takes it
    a_dest_valid_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        dest_valid && !dest_ready |=> dest_valid
    ) else $error("dest_valid dropped without a transfer");

    // Operand capture never overlaps an iteration
    a_load_step_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.load && ctrl.step)
    ) else $error("load and step asserted together");

endmodule

// ==== div_counter.sv ====
`timescale 1ns/1ps

module div_counter
    import div_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic count_load,  // Start of a division
    input  logic clear,       // Leaving the iteration phase
    output logic count_done   // One step remains
);

    logic [CNT_WIDTH-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (count_load) begin
            count <= CNT_WIDTH'(DIV_WIDTH);  // Steps still to run
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Current step is the last one when the count reaches one
    assign count_done = (count == CNT_WIDTH'(1));

endmodule

// ==== div_datapath.sv ====
`timescale 1ns/1ps

module div_datapath
    import div_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  div_operands_t operands,
    input  div_ctrl_t     ctrl,
    output logic          sub_msb,  // Sign of the partial remainder
    output div_result_t   result
);

    logic [REM_WIDTH-1:0] a_reg;    // Signed partial remainder
    logic [DIV_WIDTH-1:0] q_reg;    // Dividend shifting out, quotient shifting in
    logic [DIV_WIDTH-1:0] m_reg;    // Divisor

    logic [REM_WIDTH-1:0] m_ext;
    logic [REM_WIDTH-1:0] a_shift;
    logic [REM_WIDTH-1:0] a_next;
    logic [DIV_WIDTH-1:0] q_next;
    logic [DIV_WIDTH-1:0] rem_fix;
    div_result_t          fresh;
    div_result_t          held;

    // Operand and iteration registers
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            a_reg <= '0;
            q_reg <= operands.dividend;
            m_reg <= operands.divisor;
        end else if (ctrl.step) begin
            a_reg <= a_next;
            q_reg <= q_next;
        end
    end

    // One non-restoring iteration
    always_comb begin
        m_ext   = {1'b0, m_reg};
        a_shift = {a_reg[DIV_WIDTH-1:0], q_reg[DIV_WIDTH-1]};  // Shift A,Q left as one

        if (ctrl.alu_op == ALU_SUB) begin
            a_next = a_shift - m_ext;
        end else begin
            a_next = a_shift + m_ext;
        end

        q_next = {q_reg[DIV_WIDTH-2:0], ~a_next[DIV_WIDTH]};  // Quotient bit is inverted sign
    end

    // A negative final remainder gets the divisor added back
    always_comb begin
        if (a_next[DIV_WIDTH]) begin
            rem_fix = a_next[DIV_WIDTH-1:0] + m_reg;
        end else begin
            rem_fix = a_next[DIV_WIDTH-1:0];
        end
        fresh.quotient  = q_next;
        fresh.remainder = rem_fix;
    end

    // Result hold register for back-pressure
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= '0;
        end else if (ctrl.hold) begin
            held <= fresh;
        end
    end

    assign sub_msb = a_reg[DIV_WIDTH];
    assign result  = ctrl.hold ? fresh : held;  // Bypass in the capture cycle

    // Divisor must not move under an iteration in flight
    a_m_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ctrl.step |=> $stable(m_reg)
    ) else $error("Divisor changed during a step");

endmodule

// ==== div_pkg.sv ====
package div_pkg;

    localparam int DIV_WIDTH = 8;              // Dividend, divisor, quotient and remainder
    localparam int CNT_WIDTH = 4;              // Holds the value DIV_WIDTH
    localparam int REM_WIDTH = DIV_WIDTH + 1;  // Partial remainder carries a sign bit

    // Controller states
    typedef enum logic [1:0] {
        IDLE = 2'b00,  // Accepting operands
        RUN  = 2'b01,  // One quotient bit per cycle
        WAIT = 2'b10   // Result held until the sink takes it
    } div_state_t;

    // Operation applied in the next step
    typedef enum logic {
        ALU_ADD = 1'b0,
        ALU_SUB = 1'b1
    } alu_op_t;

    typedef struct packed {
        logic [DIV_WIDTH-1:0] dividend;
        logic [DIV_WIDTH-1:0] divisor;
    } div_operands_t;

    typedef struct packed {
        logic [DIV_WIDTH-1:0] quotient;
        logic [DIV_WIDTH-1:0] remainder;
    } div_result_t;

    // Controller to datapath bundle
    typedef struct packed {
        logic    load;    // Capture operands and clear A
        logic    step;    // Perform one iteration
        alu_op_t alu_op;  // Add or subtract the divisor
        logic    hold;    // Capture the corrected result
    } div_ctrl_t;

endpackage

// ==== seq_divider.sv ====
`timescale 1ns/1ps

module seq_divider
    import div_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          src_valid,
    input  logic          dest_ready,
    input  div_operands_t operands,
    output logic          src_ready,
    output logic          dest_valid,
    output div_result_t   result
);

    div_ctrl_t ctrl;         // Controller to datapath
    logic      count_load;
    logic      clear;
    logic      count_done;
    logic      sub_msb;

    div_controller u_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .count_done (count_done),
        .sub_msb    (sub_msb),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .count_load (count_load),
        .clear      (clear),
        .ctrl       (ctrl)
    );

    div_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .count_load (count_load),
        .clear      (clear),
        .count_done (count_done)
    );

    div_datapath u_datapath (
        .clk      (clk),
        .rst_n    (rst_n),
        .operands (operands),
        .ctrl     (ctrl),
        .sub_msb  (sub_msb),
        .result   (result)
    );

endmodule

// ==== tb_seq_divider.sv ====
`timescale 1ns/1ps

module tb_seq_divider
    import div_pkg::*;
();

    localparam int MAX_STALL    = 20;   // Longest dest_ready stall in cycles
    localparam int MAX_GAP      = 3;    // Longest src_valid gap in cycles
    localparam int NUM_DIRECTED = 9;
    localparam int NUM_STALLED  = 5;
    localparam int NUM_ZERO     = 3;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_STREAM   = 16;
    localparam int NUM_TRANSFERS = NUM_DIRECTED + NUM_STALLED + NUM_ZERO
                                 + NUM_RANDOM + NUM_STREAM;
    localparam int CYCLES_PER_TRANSFER = DIV_WIDTH + 1 + MAX_STALL + MAX_GAP + 10;
    localparam int TIMEOUT_CYCLES = NUM_TRANSFERS * CYCLES_PER_TRANSFER + 50;

    logic          clk;
    logic          rst_n;
    logic          src_valid;
    logic          dest_ready;
    div_operands_t operands;
    logic          src_ready;
    logic          dest_valid;
    div_result_t   result;

    div_result_t   exp_q[$];           // Expected results of accepted operands in arrival order
    int            accept_count = 0;
    int            result_count = 0;
    int            cycle_count  = 0;
    int            accept_cycle = 0;
    logic          busy = 1'b0;        // Accepted and dest_valid not yet seen

    seq_divider seq_divider_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .operands   (operands),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Integer division where a zero divisor gives all ones and the dividend
    function automatic div_result_t reference_result(
        input logic [DIV_WIDTH-1:0] dividend,
        input logic [DIV_WIDTH-1:0] divisor
    );
        div_result_t res;
        if (divisor == '0) begin
            res.quotient  = '1;
            res.remainder = dividend;
        end else begin
            res.quotient  = dividend / divisor;
            res.remainder = dividend % divisor;
        end
        return res;
    endfunction

    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // Transfers are taken from the values just before each rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (dest_valid) begin
                if (exp_q.size() == 0) begin
                    report_failure("dest_valid raised with no operands outstanding");
                end else begin
                    check_value("result", 32'(result), 32'(exp_q[0]));
                    if (busy) begin
                        check_value("dest_valid latency", 32'(cycle_count - accept_cycle),
                                    32'(DIV_WIDTH));
                        busy = 1'b0;
                    end
                    if (dest_ready) begin
                        void'(exp_q.pop_front());
                        result_count++;
                    end else begin
                        check_value("src_ready", 32'(src_ready), 32'd0);  // Stalled sink
                    end
                end
            end else if (src_valid && src_ready) begin
                if (exp_q.size() != 0) begin
                    report_failure("operands accepted while a division was outstanding");
                end
                exp_q.push_back(reference_result(operands.dividend, operands.divisor));
                accept_count++;
                accept_cycle = cycle_count;
                busy = 1'b1;
            end
        end
    end

    // One division with an optional src_valid gap and an optional dest_ready stall
    task automatic divide_once(
        input logic [DIV_WIDTH-1:0] dividend,
        input logic [DIV_WIDTH-1:0] divisor,
        input int                   gap,
        input int                   stall
    );
        int          accepts_before;
        int          results_before;
        div_result_t expected;

        accepts_before = accept_count;
        results_before = result_count;
        expected = reference_result(dividend, divisor);

        repeat (gap) @(negedge clk);
        operands.dividend = dividend;
        operands.divisor  = divisor;
        src_valid  = 1'b1;
        dest_ready = (stall == 0);
        while (accept_count == accepts_before) @(negedge clk);

        src_valid = 1'b0;
        operands.dividend = DIV_WIDTH'($urandom());  // Operands are don't care after accept
        operands.divisor  = DIV_WIDTH'($urandom());

        if (stall > 0) begin
            while (!dest_valid) @(negedge clk);
            repeat (stall) begin
                check_value("dest_valid", 32'(dest_valid), 32'd1);
                check_value("result", 32'(result), 32'(expected));
                check_value("src_ready", 32'(src_ready), 32'd0);
                @(negedge clk);
            end
            dest_ready = 1'b1;
        end

        while (result_count == results_before) @(negedge clk);
        dest_ready = 1'b0;
    endtask

    task automatic check_idle_after_reset();
        repeat (3) begin
            check_value("src_ready", 32'(src_ready), 32'd1);
            check_value("dest_valid", 32'(dest_valid), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic divide_directed_cases();
        divide_once(DIV_WIDTH'(100), DIV_WIDTH'(7), 0, 0);
        divide_once(DIV_WIDTH'(3), DIV_WIDTH'(9), 0, 0);     // Dividend below divisor
        divide_once(DIV_WIDTH'(42), DIV_WIDTH'(42), 0, 0);   // Equal operands
        divide_once(DIV_WIDTH'(201), DIV_WIDTH'(1), 0, 0);
        divide_once('1, '1, 0, 0);                           // Maximal operands
        divide_once('1, DIV_WIDTH'(1), 0, 0);
        divide_once('1, DIV_WIDTH'(16), 0, 0);
        divide_once(DIV_WIDTH'(0), DIV_WIDTH'(5), 0, 0);
        divide_once(DIV_WIDTH'(128), DIV_WIDTH'(3), 0, 0);
    endtask

    task automatic stall_result_port();
        int                   n;
        int                   stall;
        logic [DIV_WIDTH-1:0] dividend;
        logic [DIV_WIDTH-1:0] divisor;

        for (n = 0; n < NUM_STALLED; n++) begin
            dividend = DIV_WIDTH'($urandom());
            divisor  = DIV_WIDTH'($urandom_range((1 << DIV_WIDTH) - 1, 1));
            stall    = (n == 0) ? MAX_STALL : int'($urandom_range(MAX_STALL, 1));
            divide_once(dividend, divisor, 0, stall);
        end
    endtask

    task automatic divide_by_zero_cases();
        divide_once(DIV_WIDTH'(0), DIV_WIDTH'(0), 0, 0);
        divide_once(DIV_WIDTH'(77), DIV_WIDTH'(0), 0, 0);
        divide_once('1, DIV_WIDTH'(0), 0, 2);
    endtask

    task automatic random_traffic(input int count);
        int                   n;
        int                   gap;
        int                   stall;
        logic [DIV_WIDTH-1:0] dividend;
        logic [DIV_WIDTH-1:0] divisor;

        for (n = 0; n < count; n++) begin
            dividend = DIV_WIDTH'($urandom());
            divisor  = DIV_WIDTH'($urandom());
            if ($urandom_range(3, 0) == 0) begin
                divisor = DIV_WIDTH'($urandom_range(15, 0));  // Favour small divisors
            end
            gap = int'($urandom_range(MAX_GAP, 0));
            if ($urandom_range(2, 0) == 0) begin
                stall = int'($urandom_range(MAX_STALL, 1));
            end else begin
                stall = 0;
            end
            divide_once(dividend, divisor, gap, stall);
        end
    endtask

    // src_valid stays high and one division finishes every DIV_WIDTH+1 cycles
    task automatic stream_back_to_back(input int count);
        int n;
        int accepts_before;
        int results_before;
        int start_cycle;

        results_before = result_count;
        start_cycle = cycle_count;
        dest_ready = 1'b1;
        src_valid  = 1'b1;
        for (n = 0; n < count; n++) begin
            accepts_before = accept_count;
            operands.dividend = DIV_WIDTH'($urandom());
            operands.divisor  = DIV_WIDTH'($urandom_range((1 << DIV_WIDTH) - 1, 1));
            while (accept_count == accepts_before) @(negedge clk);
        end
        src_valid = 1'b0;

        while (result_count - results_before < count) @(negedge clk);
        dest_ready = 1'b0;
        check_value("stream cycles", 32'(cycle_count - start_cycle),
                    32'(count * (DIV_WIDTH + 1)));
    endtask

    initial begin
        void'($urandom(32'hb919));
        rst_n      = 1'b0;
        src_valid  = 1'b0;
        dest_ready = 1'b0;
        operands   = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        check_idle_after_reset();
        divide_directed_cases();
        stall_result_port();
        divide_by_zero_cases();
        random_traffic(NUM_RANDOM);
        stream_back_to_back(NUM_STREAM);
        repeat (4) @(negedge clk);

        if (exp_q.size() == 0 && accept_count == result_count) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("ERROR: %0d operand pairs accepted but %0d results delivered",
                     accept_count, result_count);
            $display("Testbench failed");
            $fatal(1);
        end
    end

endmodule

// ==== vlog.f ====
div_pkg.sv
div_controller.sv
div_counter.sv
div_datapath.sv
seq_divider.sv
tb_seq_divider.sv
